/* Makefile */
TOP = arb_burst_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/10ps -f build.f --top-module arb_burst_top
	verilator --lint-only --timing --timescale 1ns/10ps -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --timescale 1ns/10ps -f build.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "RESULT: FAIL" sim.log; then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "RESULT: PASS" sim.log || (echo "No result found in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* build.f */
+incdir+include
logic/arb_pkg.sv
logic/flow_arb_fixed.sv
logic/beat_counter.sv
logic/burst_ctrl.sv
logic/arb_data_mux.sv
logic/arb_burst_top.sv
dv/arb_burst_tb.sv

/* dv/arb_burst_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "arb_consts.svh"

module arb_burst_tb import arb_pkg::*; ();

  // --------------------------------------------------
  // Run limits
  // --------------------------------------------------

  // Summed length of all tests
  // Hard stop at twice that
  localparam int TEST_CYCLES    = 2000;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;
  // Room for 24 bursts of up to 16 beats per requester
  localparam int SCRIPT_DEPTH   = 512;

  logic                     clk;
  logic                     rst_n;
  logic [`ARB_NUM_REQ-1:0]  push_valid;
  beat_u [`ARB_NUM_REQ-1:0] push_data;
  logic [`ARB_NUM_REQ-1:0]  push_ready;
  logic                     pop_valid;
  beat_u                    pop_data;
  logic [`ARB_IDX_W-1:0]    pop_src;
  logic                     pop_last;
  logic                     pop_ready;

  // Beat scripts, one per requester
  logic [`ARB_BEAT_W-1:0]  script [`ARB_NUM_REQ][SCRIPT_DEPTH];
  int                      rd_ptr [`ARB_NUM_REQ];
  int                      wr_ptr [`ARB_NUM_REQ];
  // Requester has raised valid and waits for its accept
  logic [`ARB_NUM_REQ-1:0] held;

  // Reference model of the burst lock
  logic                    model_open;
  int                      model_owner;
  logic [`ARB_LEN_W-1:0]   model_left;

  // Expectation formed in the current cycle
  logic                    exp_hit;
  int                      exp_g;
  logic                    acc;
  beat_u                   acc_beat;

  logic [31:0]             seed;
  int                      check_cnt;
  int                      err_cnt;
  int                      beat_cnt;
  int                      test_cnt;
  int                      cycle_cnt;

  arb_burst_top dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_data  (push_data),
    .push_ready (push_ready),
    .pop_valid  (pop_valid),
    .pop_data   (pop_data),
    .pop_src    (pop_src),
    .pop_last   (pop_last),
    .pop_ready  (pop_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Hard stop if some requester never drains
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, scripts were not drained", cycle_cnt);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic all_drained();
    for (int i = 0; i < `ARB_NUM_REQ; i++) begin
      if (rd_ptr[i] < wr_ptr[i]) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    check_cnt++;
    if (exp_v !== act_v) begin
      err_cnt++;
      $display("FAIL t=%0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
    end
  endtask

  // Header with random len and tag, then len random payload beats
  task automatic build_scripts(input int bursts, input int max_len);
    logic [31:0]           r;
    logic [`ARB_LEN_W-1:0] len;
    for (int i = 0; i < `ARB_NUM_REQ; i++) begin
      rd_ptr[i] = 0;
      wr_ptr[i] = 0;
      held[i]   = 1'b0;
      for (int b = 0; b < bursts; b++) begin
        r   = next_rand();
        len = `ARB_LEN_W'((r >> 20) % (max_len + 1));
        script[i][wr_ptr[i]] = {len, r[`ARB_TAG_W-1:0]};
        wr_ptr[i]++;
        for (int p = 0; p < int'(len); p++) begin
          r = next_rand();
          script[i][wr_ptr[i]] = r[31:16];
          wr_ptr[i]++;
        end
      end
    end
  endtask

  task automatic drive_inputs(input int valid_pct, input int ready_pct);
    logic [31:0] r;
    for (int i = 0; i < `ARB_NUM_REQ; i++) begin
      r = next_rand();
      if (!held[i] && (rd_ptr[i] < wr_ptr[i]) && (((r >> 8) % 100) < valid_pct)) begin
        held[i] = 1'b1;
      end
      push_valid[i] = held[i];
      // Idle requesters put junk on their data lines
      if (held[i]) begin
        push_data[i].raw = script[i][rd_ptr[i]];
      end else begin
        push_data[i].raw = r[31:16];
      end
    end
    r = next_rand();
    pop_ready = (((r >> 8) % 100) < ready_pct);
  endtask

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------

  task automatic check_outputs();
    logic [`ARB_NUM_REQ-1:0] exp_ready;
    logic                    exp_last;
    beat_u                   exp_beat;
    exp_hit   = 1'b0;
    exp_g     = 0;
    exp_ready = '0;
    exp_beat  = '0;
    // Owner only while locked, else lowest valid index
    if (model_open) begin
      if (push_valid[model_owner]) begin
        exp_hit = 1'b1;
        exp_g   = model_owner;
      end
    end else begin
      for (int i = `ARB_NUM_REQ - 1; i >= 0; i--) begin
        if (push_valid[i]) begin
          exp_hit = 1'b1;
          exp_g   = i;
        end
      end
    end
    if (exp_hit) exp_beat.raw = script[exp_g][rd_ptr[exp_g]];
    if (exp_hit && pop_ready) exp_ready[exp_g] = 1'b1;
    // Last beat is the 1 + len-th one of the burst
    if (model_open) begin
      exp_last = (model_left == `ARB_LEN_W'(1));
    end else begin
      exp_last = (exp_beat.hdr.len == '0);
    end
    check_val("push_ready", 32'(exp_ready), 32'(push_ready));
    check_val("pop_valid", 32'(exp_hit), 32'(pop_valid));
    if (exp_hit) begin
      check_val("pop_data", 32'(exp_beat.raw), 32'(pop_data.raw));
      check_val("pop_src", 32'(exp_g), 32'(pop_src));
      check_val("pop_last", 32'(exp_last), 32'(pop_last));
    end
    acc      = exp_hit && pop_ready;
    acc_beat = exp_beat;
  endtask

  task automatic update_model();
    if (acc) begin
      beat_cnt++;
      rd_ptr[exp_g]++;
      held[exp_g] = 1'b0;
      if (!model_open) begin
        if (acc_beat.hdr.len != '0) begin
          model_open  = 1'b1;
          model_owner = exp_g;
          model_left  = acc_beat.hdr.len;
        end
      end else begin
        model_left = model_left - `ARB_LEN_W'(1);
        if (model_left == '0) model_open = 1'b0;
      end
    end
  endtask

  // One test runs until every script beat has been popped
  task automatic run_test(input string name, input int bursts, input int max_len,
                          input int valid_pct, input int ready_pct);
    int errs0;
    int beats0;
    errs0  = err_cnt;
    beats0 = beat_cnt;
    build_scripts(bursts, max_len);
    while (!all_drained()) begin
      @(negedge clk);
      drive_inputs(valid_pct, ready_pct);
      #1;
      check_outputs();
      @(posedge clk);
      update_model();
    end
    test_cnt++;
    $display("test %-12s beats %0d errors %0d", name, beat_cnt - beats0, err_cnt - errs0);
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin
    seed        = 32'h9dd5_b5cf;
    rst_n       = 1'b0;
    push_valid  = '0;
    push_data   = '0;
    pop_ready   = 1'b0;
    held        = '0;
    model_open  = 1'b0;
    model_owner = 0;
    model_left  = '0;
    acc         = 1'b0;
    check_cnt   = 0;
    err_cnt     = 0;
    beat_cnt    = 0;
    test_cnt    = 0;
    cycle_cnt   = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // All headers at once on an idle bus
    run_test("priority", 1, 3, 100, 100);
    // Long bursts while others raise valid at random
    run_test("lock", 2, 15, 40, 100);
    // Pop side mostly stalled
    run_test("backpressure", 2, 7, 80, 25);
    run_test("zero_len", 4, 0, 70, 90);
    run_test("last_release", 3, 15, 90, 75);
    run_test("random_mix", 24, 15, 75, 75);
    $display("tests %0d beats %0d checks %0d errors %0d",
             test_cnt, beat_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule : arb_burst_tb

`default_nettype wire

/* include/arb_consts.svh */
`ifndef ARB_CONSTS_SVH
`define ARB_CONSTS_SVH

// Number of requesters on the push side
`define ARB_NUM_REQ 4

// Width of one beat word
`define ARB_BEAT_W 16

// Header length field gives 0 to 15 payload beats
`define ARB_LEN_W 4
`define ARB_TAG_W 12

// Width of the encoded source index
`define ARB_IDX_W 2

`endif

/* logic/arb_burst_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "arb_consts.svh"

// Burst arbiter top
// Several ready/valid requesters share one pop port one burst at a time
module arb_burst_top import arb_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [`ARB_NUM_REQ-1:0]  push_valid,
  input  beat_u [`ARB_NUM_REQ-1:0] push_data,
  output logic [`ARB_NUM_REQ-1:0]  push_ready,
  output logic                     pop_valid,
  output beat_u                    pop_data,
  output logic [`ARB_IDX_W-1:0]    pop_src,
  output logic                     pop_last,
  input  logic                     pop_ready
);

  // --------------------------------------------------
  // Internal wires
  // --------------------------------------------------

  logic [`ARB_NUM_REQ-1:0] grant;
  logic [`ARB_NUM_REQ-1:0] lock_grant;
  logic                    fire;
  logic                    lock;
  logic                    load;
  logic                    step;
  logic                    remaining_one;

  // --------------------------------------------------
  // Control
  // --------------------------------------------------

  // Combinational grant and handshake
  flow_arb_fixed flow_arb_fixed_i (
    .push_valid (push_valid),
    .pop_ready  (pop_ready),
    .lock       (lock),
    .lock_grant (lock_grant),
    .push_ready (push_ready),
    .pop_valid  (pop_valid),
    .grant      (grant),
    .fire       (fire)
  );

  // Holds the grant for the length of a burst
  burst_ctrl burst_ctrl_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .fire          (fire),
    .grant         (grant),
    .pop_beat      (pop_data),
    .remaining_one (remaining_one),
    .lock          (lock),
    .lock_grant    (lock_grant),
    .load          (load),
    .step          (step),
    .pop_last      (pop_last)
  );

  // Length comes straight from the header on the bus
  beat_counter beat_counter_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .load          (load),
    .load_len      (pop_data.hdr.len),
    .step          (step),
    .remaining_one (remaining_one)
  );

  // --------------------------------------------------
  // Data
  // --------------------------------------------------

  arb_data_mux arb_data_mux_i (
    .grant     (grant),
    .push_data (push_data),
    .pop_data  (pop_data),
    .pop_src   (pop_src)
  );

endmodule : arb_burst_top

`default_nettype wire

/* logic/arb_data_mux.sv */
`timescale 1ns/10ps
`default_nettype none

`include "arb_consts.svh"

// Data path of the arbiter
// AND-OR select of the granted beat plus a one-hot to index encoder
module arb_data_mux import arb_pkg::*; (
  input  logic [`ARB_NUM_REQ-1:0] grant,
  input  beat_u [`ARB_NUM_REQ-1:0] push_data,
  output beat_u                    pop_data,
  output logic [`ARB_IDX_W-1:0]    pop_src
);

  // --------------------------------------------------
  // Select and encode
  // --------------------------------------------------

  always_comb begin
    pop_data.raw = '0;
    pop_src      = '0;
    for (int i = 0; i < `ARB_NUM_REQ; i++) begin
      // Grant is one-hot so at most one term survives
      pop_data.raw = pop_data.raw | (push_data[i].raw & {`ARB_BEAT_W{grant[i]}});
      if (grant[i]) begin
        pop_src = pop_src | `ARB_IDX_W'(i);
      end
    end
  end

endmodule : arb_data_mux

`default_nettype wire

/* logic/arb_pkg.sv */
`default_nettype none

`include "arb_consts.svh"

package arb_pkg;

  // --------------------------------------------------
  // Beat word views
  // --------------------------------------------------

  // Header view of the first beat of a burst
  // Length sits in the upper bits and the tag fills the rest
  typedef struct packed {
    logic [`ARB_LEN_W-1:0] len;
    logic [`ARB_TAG_W-1:0] tag;
  } beat_hdr_s;

  // One beat on the bus
  // Read as hdr at the start of a burst and as raw for payload
  typedef union packed {
    beat_hdr_s             hdr;
    logic [`ARB_BEAT_W-1:0] raw;
  } beat_u;

endpackage : arb_pkg

`default_nettype wire

/* logic/beat_counter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "arb_consts.svh"

// Counts payload beats still owed by the open burst
module beat_counter (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  load,
  input  logic [`ARB_LEN_W-1:0] load_len,
  input  logic                  step,
  output logic                  remaining_one
);

  // --------------------------------------------------
  // Count register
  // --------------------------------------------------

  logic [`ARB_LEN_W-1:0] count_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (load) begin
      // Header accepted, so len payload beats follow
      count_q <= load_len;
    end else if (step && (count_q != '0)) begin
      // One payload beat gone
      count_q <= count_q - 1'b1;
    end
  end

  // --------------------------------------------------
  // Status
  // --------------------------------------------------

  // Beat now on the bus is the final payload beat
  assign remaining_one = (count_q == `ARB_LEN_W'(1));

endmodule : beat_counter

`default_nettype wire

/* logic/burst_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

`include "arb_consts.svh"

// Burst lock FSM
// Opens on a header with payload and closes after the last payload beat
module burst_ctrl import arb_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    fire,
  input  logic [`ARB_NUM_REQ-1:0] grant,
  input  beat_u                   pop_beat,
  input  logic                    remaining_one,
  output logic                    lock,
  output logic [`ARB_NUM_REQ-1:0] lock_grant,
  output logic                    load,
  output logic                    step,
  output logic                    pop_last
);

  // --------------------------------------------------
  // State
  // --------------------------------------------------

  typedef enum logic {
    st_idle,
    st_locked
  } arb_state_e;

  arb_state_e              state_q;
  arb_state_e              state_d;
  logic [`ARB_NUM_REQ-1:0] lock_grant_q;
  logic                    hdr_has_payload;

  // In idle the beat on the bus is always a header
  assign hdr_has_payload = (pop_beat.hdr.len != '0);

  // --------------------------------------------------
  // Next state and strobes
  // --------------------------------------------------

  always_comb begin
    state_d  = state_q;
    load     = 1'b0;
    step     = 1'b0;
    pop_last = 1'b0;
    case (state_q)
      st_idle: begin
        // Zero length header is a whole burst on its own
        pop_last = (|grant) && !hdr_has_payload;
        if (fire && hdr_has_payload) begin
          load    = 1'b1;
          state_d = st_locked;
        end
      end
      st_locked: begin
        pop_last = remaining_one;
        if (fire) begin
          step = 1'b1;
          // Last payload beat releases the bus
          if (remaining_one) begin
            state_d = st_idle;
          end
        end
      end
      default: begin
        state_d = st_idle;
      end
    endcase
  end

  // --------------------------------------------------
  // Registers
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q      <= st_idle;
      lock_grant_q <= '0;
    end else begin
      state_q <= state_d;
      // Remember who owns the burst
      if (load) begin
        lock_grant_q <= grant;
      end
    end
  end

  assign lock       = (state_q == st_locked);
  assign lock_grant = lock_grant_q;

endmodule : burst_ctrl

`default_nettype wire

/* logic/flow_arb_fixed.sv */
`timescale 1ns/10ps
`default_nettype none

`include "arb_consts.svh"

// Fixed-priority arbiter with ready/valid on both sides
// Lowest index wins while no burst is open
// An open burst overrides the pick with the held grant
module flow_arb_fixed (
  input  logic [`ARB_NUM_REQ-1:0] push_valid,
  input  logic                    pop_ready,
  input  logic                    lock,
  input  logic [`ARB_NUM_REQ-1:0] lock_grant,
  output logic [`ARB_NUM_REQ-1:0] push_ready,
  output logic                    pop_valid,
  output logic [`ARB_NUM_REQ-1:0] grant,
  output logic                    fire
);

  // --------------------------------------------------
  // Priority pick
  // --------------------------------------------------

  logic [`ARB_NUM_REQ-1:0] prio_grant;

  // Scan from index 0 upward and keep the first valid
  always_comb begin : pick_lowest
    logic found;
    found      = 1'b0;
    prio_grant = '0;
    for (int i = 0; i < `ARB_NUM_REQ; i++) begin
      if (push_valid[i] && !found) begin
        prio_grant[i] = 1'b1;
        found         = 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Grant and handshake
  // --------------------------------------------------

  // Held requester only, and only while it presents a beat
  assign grant = lock ? (lock_grant & push_valid) : prio_grant;

  // Something is on the pop port whenever a grant is live
  assign pop_valid = |grant;

  // Ready goes back only to the granted requester
  // Low pop_ready stalls every push
  assign push_ready = grant & {`ARB_NUM_REQ{pop_ready}};

  // Single accept strobe shared with the control logic
  assign fire = pop_valid & pop_ready;

endmodule : flow_arb_fixed

`default_nettype wire
